/* flist.f */
hdl/usb_tx_pkg.sv
hdl/usb_tx_fifo.sv
hdl/usb_tx_apb_regs.sv
hdl/usb_tx_controller.sv
hdl/usb_tx_crc16.sv
hdl/usb_tx_encoder.sv
hdl/usb_tx_top.sv
bench/usb_tx_clkgen.sv
bench/usb_tx_tb.sv

/* Makefile */
# Verilator build and run for the USB transmitter

VERILATOR ?= verilator
TOP ?= usb_tx_tb
RTL_TOP ?= usb_tx_top
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_STR ?= ALL TESTS PASSED

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Result comes from the simulation output only
sim: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/usb_tx_tb.sv */
/*
 * Testbench for the USB transmitter
 * APB tasks, NRZI line decoder with destuffing, reference CRC16,
 * line and bus assertions, directed and random packet tests
 */
`default_nettype none

module usb_tx_tb;

	localparam int BIT_CLKS = usb_tx_pkg::BIT_CLKS;
	localparam int DEPTH = usb_tx_pkg::FIFO_DEPTH;
	localparam int PACKETS = 8;
	// 12 bytes of 10 bit times per packet at most, five times over
	localparam int MAX_CYCLES = 5 * PACKETS * 12 * 10 * BIT_CLKS;

	logic clk;
	logic n_rst;
	usb_tx_pkg::apb_req_t apb_req;
	usb_tx_pkg::apb_rsp_t apb_rsp;
	usb_tx_pkg::usb_line_t line;
	logic busy;

	integer seed;
	int errors = 0;
	int tests = 0;
	int failed = 0;
	int mark = 0;
	int cycles = 0;
	int len;
	logic cap_err;
	logic [31:0] cap_rdata;
	logic [7:0] tx_data [$];

	// Decoder state
	logic [7:0] rx_bytes [$];
	logic [7:0] rx_shift;
	logic oe_q = 1'b0;
	logic prev_level;
	logic nrzi_bit;
	logic in_eop;
	int bit_pos;
	int rx_nbits;
	int ones_run;
	int stuff_count;
	int se0_cycles;
	int j_cycles;

	usb_tx_clkgen clkgen_inst (.clk(clk), .n_rst(n_rst));

	usb_tx_top usb_tx_top_inst (
		.clk(clk), .n_rst(n_rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.line(line), .busy(busy)
	);

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Response of the access phase
	always @(posedge clk) begin
		if (apb_req.psel && apb_req.penable) begin
			cap_err <= apb_rsp.pslverr;
			cap_rdata <= apb_rsp.prdata;
		end
	end

	// Samples mid bit time, undoes NRZI and stuffing, times the EOP
	always @(negedge clk) begin
		if (line.oe) begin
			if (!oe_q) begin
				rx_bytes.delete();
				bit_pos = 0;
				prev_level = 1'b1;
				rx_nbits = 0;
				ones_run = 0;
				stuff_count = 0;
				se0_cycles = 0;
				j_cycles = 0;
				in_eop = 1'b0;
			end
			if (!line.dp && !line.dm) begin
				se0_cycles++;
				in_eop = 1'b1;
			end else if (in_eop) begin
				if (line.dp)
					j_cycles++;
			end else if (bit_pos == BIT_CLKS / 2) begin
				nrzi_bit = (line.dp == prev_level);
				prev_level = line.dp;
				if (ones_run == 6) begin
					assert (!nrzi_bit) else begin
						$display("Error: seventh one in a row, stuffed zero missing");
						errors++;
					end
					if (!nrzi_bit)
						stuff_count++;
					ones_run = 0;
				end else begin
					ones_run = nrzi_bit ? ones_run + 1 : 0;
					rx_shift = {nrzi_bit, rx_shift[7:1]};
					rx_nbits++;
					if (rx_nbits == 8) begin
						rx_bytes.push_back(rx_shift);
						rx_nbits = 0;
					end
				end
			end
			bit_pos = (bit_pos + 1) % BIT_CLKS;
		end
		oe_q = line.oe;
	end

	a_no_se1: assert property (@(posedge clk) disable iff (!n_rst)
		!(line.dp && line.dm))
		else begin $display("Error: dp and dm both high"); errors++; end
	a_idle_j: assert property (@(posedge clk) disable iff (!n_rst)
		!line.oe |-> (line.dp && !line.dm))
		else begin $display("Error: line not J while oe is low"); errors++; end
	a_oe_busy: assert property (@(posedge clk) disable iff (!n_rst)
		line.oe |-> busy)
		else begin $display("Error: oe high while not busy"); errors++; end
	a_oe_rise: assert property (@(posedge clk) disable iff (!n_rst)
		$rose(busy) |=> $rose(line.oe))
		else begin $display("Error: oe did not rise two cycles after start"); errors++; end
	a_end_align: assert property (@(posedge clk) disable iff (!n_rst)
		$fell(busy) == $fell(line.oe))
		else begin $display("Error: oe and busy did not fall together"); errors++; end
	a_pready: assert property (@(posedge clk) disable iff (!n_rst)
		apb_rsp.pready)
		else begin $display("Error: pready low"); errors++; end
	a_err_access: assert property (@(posedge clk) disable iff (!n_rst)
		apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
		else begin $display("Error: pslverr outside an access phase"); errors++; end

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		assert (exp == got) else begin
			$display("Fail %s: expected %h, got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("Error: %s", what);
			errors++;
		end
	endtask

	// Entered and left on a falling edge
	task automatic apb_access(input logic write, input logic [7:0] addr,
		input logic [31:0] data);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = write;
		apb_req.paddr = addr;
		apb_req.pwdata = data;
		@(negedge clk);
		apb_req.penable = 1'b1;
		@(negedge clk);
		apb_req = '0;
	endtask

	function automatic logic [15:0] reference_crc();
		logic [15:0] rem;
		logic fb;
		rem = usb_tx_pkg::CRC_INIT;
		foreach (tx_data[i])
			for (int b = 0; b < 8; b++) begin
				fb = rem[0] ^ tx_data[i][b];
				rem = rem >> 1;
				if (fb)
					rem = rem ^ usb_tx_pkg::CRC_POLY;
			end
		return ~rem;
	endfunction

	task automatic load_fifo(input logic [7:0] pid);
		apb_access(1'b1, usb_tx_pkg::ADDR_DATA, {24'h0, pid});
		check_value("pslverr", 32'h0, 32'(cap_err));
		foreach (tx_data[i]) begin
			apb_access(1'b1, usb_tx_pkg::ADDR_DATA, {24'h0, tx_data[i]});
			check_value("pslverr", 32'h0, 32'(cap_err));
		end
	endtask

	task automatic start_packet();
		apb_access(1'b1, usb_tx_pkg::ADDR_CTRL, 32'h1);
		check_value("pslverr", 32'h0, 32'(cap_err));
		check_true(busy, "packet did not start");
	endtask

	task automatic wait_idle();
		while (busy)
			@(negedge clk);
	endtask

	task automatic check_packet(input logic [7:0] pid);
		logic [15:0] crc;
		logic [7:0] exp_bytes [$];
		crc = reference_crc();
		exp_bytes.push_back(usb_tx_pkg::SYNC_BYTE);
		exp_bytes.push_back(pid);
		foreach (tx_data[i])
			exp_bytes.push_back(tx_data[i]);
		exp_bytes.push_back(crc[7:0]);
		exp_bytes.push_back(crc[15:8]);
		check_value("rx_bytes.size", 32'(exp_bytes.size()), 32'(rx_bytes.size()));
		foreach (exp_bytes[i])
			if (i < rx_bytes.size())
				check_value($sformatf("rx_bytes[%0d]", i), 32'(exp_bytes[i]),
					32'(rx_bytes[i]));
		check_value("se0_cycles", 2 * BIT_CLKS, se0_cycles);
		check_value("j_cycles", BIT_CLKS, j_cycles);
	endtask

	task automatic send_packet(input logic [7:0] pid);
		load_fifo(pid);
		start_packet();
		wait_idle();
		check_packet(pid);
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == mark) begin
			$display("test %0d %s: passed", tests, name);
		end else begin
			failed++;
			$display("test %0d %s: failed with %0d errors", tests, name, errors - mark);
		end
		mark = errors;
	endtask

	initial begin
		apb_req = '0;
		seed = 32'h324e60dc;
		@(posedge n_rst);
		@(negedge clk);

		check_value("line.oe", 32'h0, 32'(line.oe));
		check_value("busy", 32'h0, 32'(busy));
		check_value("line.dp", 32'h1, 32'(line.dp));
		check_value("line.dm", 32'h0, 32'(line.dm));
		apb_access(1'b0, usb_tx_pkg::ADDR_STATUS, 32'h0);
		check_value("prdata", 32'h02, cap_rdata);
		report_test("reset state");

		tx_data.delete();
		repeat (3) tx_data.push_back(8'($random(seed)));
		send_packet(8'hC3);
		report_test("pid and three random bytes");

		tx_data.delete();
		repeat (3) tx_data.push_back(8'hFF);
		send_packet(8'h4B);
		check_true(stuff_count >= 4, "too few stuffed zeros for 0xFF data");
		report_test("bit stuffing on 0xFF data");

		apb_access(1'b1, usb_tx_pkg::ADDR_CTRL, 32'h1);
		check_value("pslverr", 32'h1, 32'(cap_err));
		repeat (4) @(negedge clk);
		check_true(!line.oe && !busy, "start with an empty FIFO caused line activity");
		tx_data.delete();
		repeat (DEPTH - 1) tx_data.push_back(8'($random(seed)));
		load_fifo(8'h4B);
		apb_access(1'b1, usb_tx_pkg::ADDR_DATA, 32'h5A);
		check_value("pslverr", 32'h1, 32'(cap_err));
		apb_access(1'b0, usb_tx_pkg::ADDR_STATUS, 32'h0);
		check_value("prdata", 32'h84, cap_rdata);
		start_packet();
		apb_access(1'b1, usb_tx_pkg::ADDR_CTRL, 32'h1);
		check_value("pslverr", 32'h1, 32'(cap_err));
		wait_idle();
		check_packet(8'h4B);
		report_test("register errors");

		tx_data.delete();
		tx_data.push_back(8'($random(seed)));
		send_packet(8'hC3);
		report_test("end of packet timing");

		repeat (4) begin
			len = 1 + ($unsigned($random(seed)) % 32'(DEPTH));
			tx_data.delete();
			repeat (len - 1) tx_data.push_back(8'($random(seed)));
			send_packet(tx_data.size() % 2 == 0 ? 8'hC3 : 8'h4B);
		end
		report_test("back-to-back random packets");

		$display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/usb_tx_clkgen.sv */
/*
 * Testbench clock and reset source
 */
`default_nettype none

module usb_tx_clkgen (
	output logic clk,
	output logic n_rst
);

	localparam int PERIOD = 8;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Released on a falling edge after two periods
	initial begin
		n_rst = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		n_rst = 1'b1;
	end

endmodule

`default_nettype wire

/* hdl/usb_tx_top.sv */
/*
 * USB full-speed packet transmitter top level
 * APB registers, FIFO, controller, CRC16 and line encoder
 */
`default_nettype none

module usb_tx_top (
	input logic clk,
	input logic n_rst,
	input usb_tx_pkg::apb_req_t apb_req,
	output usb_tx_pkg::apb_rsp_t apb_rsp,
	output usb_tx_pkg::usb_line_t line,
	output logic busy
);

	usb_tx_pkg::tx_cmd_t cmd;
	logic push;
	logic pop;
	logic start;
	logic [7:0] wdata;
	logic [7:0] fifo_byte;
	logic fifo_empty;
	logic fifo_full;
	logic [3:0] fifo_count;
	logic crc_clear;
	logic crc_enable;
	logic [15:0] crc;
	logic byte_sent;

	usb_tx_apb_regs regs_inst (
		.clk(clk), .n_rst(n_rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.busy(busy), .fifo_empty(fifo_empty), .fifo_full(fifo_full),
		.fifo_count(fifo_count), .push(push), .wdata(wdata), .start(start)
	);

	usb_tx_fifo fifo_inst (
		.clk(clk), .n_rst(n_rst), .push(push), .wdata(wdata), .pop(pop),
		.rdata(fifo_byte), .empty(fifo_empty), .full(fifo_full), .count(fifo_count)
	);

	usb_tx_controller ctrl_inst (
		.clk(clk), .n_rst(n_rst), .start(start), .data_sent(fifo_empty),
		.byte_sent(byte_sent), .cmd(cmd), .read_enable(pop),
		.crc_clear(crc_clear), .crc_enable(crc_enable), .busy(busy)
	);

	usb_tx_crc16 crc_inst (
		.clk(clk), .n_rst(n_rst), .clear(crc_clear), .enable(crc_enable),
		.data(fifo_byte), .crc(crc)
	);

	usb_tx_encoder enc_inst (
		.clk(clk), .n_rst(n_rst), .cmd(cmd), .fifo_byte(fifo_byte), .crc(crc),
		.byte_sent(byte_sent), .line(line)
	);

endmodule

`default_nettype wire

/* hdl/usb_tx_encoder.sv */
/*
 * USB line encoder
 * Bit timing, one byte holding register, LSB first shifter,
 * bit stuffing, NRZI and EOP generation
 */
`default_nettype none

module usb_tx_encoder (
	input logic clk,
	input logic n_rst,
	input usb_tx_pkg::tx_cmd_t cmd,
	input logic [7:0] fifo_byte,
	input logic [15:0] crc,
	output logic byte_sent,
	output usb_tx_pkg::usb_line_t line
);

	localparam int CW = $clog2(usb_tx_pkg::BIT_CLKS);

	typedef enum logic [1:0] {M_IDLE, M_DATA, M_SE0, M_J} mode_t;

	mode_t mode;
	logic [CW-1:0] clk_cnt;
	logic [7:0] sel_byte;
	logic [7:0] shreg;
	logic [7:0] hold;
	logic [3:0] bits_left;
	logic [2:0] ones;
	logic hold_valid;
	logic eop_req;
	logic eop_cnt;
	logic level;
	logic oe;
	logic tick;
	logic stuff;
	logic take;

	always_comb begin
		case (cmd.sel)
			usb_tx_pkg::SEL_SYNC: sel_byte = usb_tx_pkg::SYNC_BYTE;
			usb_tx_pkg::SEL_FIFO: sel_byte = fifo_byte;
			usb_tx_pkg::SEL_CRC_LO: sel_byte = crc[7:0];
			default: sel_byte = crc[15:8];
		endcase
	end

	// tick marks the last cycle of a bit time
	assign tick = (mode != M_IDLE) && (clk_cnt == CW'(usb_tx_pkg::BIT_CLKS - 1));
	assign stuff = (ones == 3'd6);
	assign take = !stuff && (bits_left == 4'd0) && hold_valid;
	assign byte_sent = tick && cmd.tx_enable && (((mode == M_DATA) && take) || (mode == M_J));

	always_ff @(posedge clk) begin
		if (cmd.load && mode != M_IDLE)
			hold <= sel_byte;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			mode <= M_IDLE;
			clk_cnt <= '0;
			shreg <= '0;
			bits_left <= '0;
			ones <= '0;
			hold_valid <= 1'b0;
			eop_req <= 1'b0;
			eop_cnt <= 1'b0;
			level <= 1'b1;
			oe <= 1'b0;
		end else begin
			if (mode != M_IDLE)
				clk_cnt <= tick ? '0 : clk_cnt + 1'b1;
			if (cmd.create_eop)
				eop_req <= 1'b1;
			case (mode)
				M_IDLE: begin
					// First byte goes straight onto the line
					if (cmd.load) begin
						mode <= M_DATA;
						oe <= 1'b1;
						clk_cnt <= '0;
						eop_req <= 1'b0;
						shreg <= {1'b0, sel_byte[7:1]};
						bits_left <= 4'd7;
						ones <= sel_byte[0] ? 3'd1 : 3'd0;
						level <= sel_byte[0] ? level : ~level;
					end
				end
				M_DATA: begin
					if (tick) begin
						if (stuff) begin
							ones <= '0;
							level <= ~level;
						end else if (bits_left != 4'd0) begin
							shreg <= shreg >> 1;
							bits_left <= bits_left - 1'b1;
							ones <= shreg[0] ? 3'(ones + 1'b1) : 3'd0;
							level <= shreg[0] ? level : ~level;
						end else if (hold_valid) begin
							shreg <= hold >> 1;
							bits_left <= 4'd7;
							hold_valid <= 1'b0;
							// Run of ones carries across the byte boundary
							ones <= hold[0] ? 3'(ones + 1'b1) : 3'd0;
							level <= hold[0] ? level : ~level;
						end else if (eop_req) begin
							mode <= M_SE0;
							eop_cnt <= 1'b0;
							eop_req <= 1'b0;
							ones <= '0;
						end
					end
				end
				M_SE0: begin
					if (tick) begin
						if (eop_cnt) begin
							mode <= M_J;
							level <= 1'b1;
						end else begin
							eop_cnt <= 1'b1;
						end
					end
				end
				default: begin
					if (tick) begin
						mode <= M_IDLE;
						oe <= 1'b0;
					end
				end
			endcase
			if (cmd.load && mode != M_IDLE)
				hold_valid <= 1'b1;
		end
	end

	assign line.oe = oe;
	assign line.dp = (mode != M_SE0) && level;
	assign line.dm = (mode != M_SE0) && !level;

	a_no_se1: assert property (@(posedge clk) disable iff (!n_rst)
		!(line.dp && line.dm));

endmodule

`default_nettype wire

/* hdl/usb_tx_crc16.sv */
/*
 * CRC16 generator for USB data packets
 * One byte per cycle, LSB first, inverted result
 */
`default_nettype none

module usb_tx_crc16 (
	input logic clk,
	input logic n_rst,
	input logic clear,
	input logic enable,
	input logic [7:0] data,
	output logic [15:0] crc
);

	logic [15:0] remainder;
	logic [15:0] next_rem;

	always_comb begin
		next_rem = remainder ^ {8'h00, data};
		for (int i = 0; i < 8; i++) begin
			if (next_rem[0])
				next_rem = (next_rem >> 1) ^ usb_tx_pkg::CRC_POLY;
			else
				next_rem = next_rem >> 1;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			remainder <= usb_tx_pkg::CRC_INIT;
		else if (clear)
			remainder <= usb_tx_pkg::CRC_INIT;
		else if (enable)
			remainder <= next_rem;
	end

	assign crc = ~remainder;

endmodule

`default_nettype wire

/* hdl/usb_tx_controller.sv */
/*
 * Transmit packet sequencer
 * SYNC, PID, data bytes with CRC16 update, CRC low/high, then EOP
 */
`default_nettype none

module usb_tx_controller (
	input logic clk,
	input logic n_rst,
	input logic start,
	input logic data_sent,
	input logic byte_sent,
	output usb_tx_pkg::tx_cmd_t cmd,
	output logic read_enable,
	output logic crc_clear,
	output logic crc_enable,
	output logic busy
);

	typedef enum logic [3:0] {
		IDLE, LOAD_INIT, LOAD_PID, TRANSMIT_INIT, READ_INIT, POP_WAIT, CHK_DATA,
		LOAD, START_TX, READ, LOAD_CRC, TX_CRC, CREATE_EOP, EOP_WAIT
	} state_t;

	state_t state;
	state_t next_state;
	logic read_enable_delay;
	logic crc_phase;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= IDLE;
			read_enable <= 1'b0;
			crc_phase <= 1'b0;
		end else begin
			state <= next_state;
			read_enable <= read_enable_delay;
			if (state == IDLE)
				crc_phase <= 1'b0;
			else if (state == TX_CRC && byte_sent)
				crc_phase <= 1'b1;
		end
	end

	// The encoder holds one byte ahead, so each load happens while
	// the previous byte is still on the line
	always_comb begin
		next_state = state;
		cmd = '0;
		read_enable_delay = 1'b0;
		crc_clear = 1'b0;
		crc_enable = 1'b0;
		case (state)
			IDLE: begin
				crc_clear = 1'b1;
				if (start)
					next_state = LOAD_INIT;
			end
			LOAD_INIT: begin
				cmd.load = 1'b1;
				cmd.sel = usb_tx_pkg::SEL_SYNC;
				next_state = LOAD_PID;
			end
			LOAD_PID: begin
				cmd.load = 1'b1;
				cmd.sel = usb_tx_pkg::SEL_FIFO;
				next_state = TRANSMIT_INIT;
			end
			TRANSMIT_INIT: begin
				cmd.tx_enable = 1'b1;
				if (byte_sent)
					next_state = READ_INIT;
			end
			// PID is not part of the CRC
			READ_INIT: begin
				read_enable_delay = 1'b1;
				next_state = POP_WAIT;
			end
			POP_WAIT:
				next_state = CHK_DATA;
			CHK_DATA: begin
				if (data_sent)
					next_state = LOAD_CRC;
				else
					next_state = LOAD;
			end
			LOAD: begin
				cmd.load = 1'b1;
				cmd.sel = usb_tx_pkg::SEL_FIFO;
				next_state = START_TX;
			end
			START_TX: begin
				cmd.tx_enable = 1'b1;
				if (byte_sent)
					next_state = READ;
			end
			READ: begin
				read_enable_delay = 1'b1;
				crc_enable = 1'b1;
				next_state = POP_WAIT;
			end
			LOAD_CRC: begin
				cmd.load = 1'b1;
				cmd.sel = crc_phase ? usb_tx_pkg::SEL_CRC_HI : usb_tx_pkg::SEL_CRC_LO;
				next_state = TX_CRC;
			end
			TX_CRC: begin
				cmd.tx_enable = 1'b1;
				if (byte_sent)
					next_state = crc_phase ? CREATE_EOP : LOAD_CRC;
			end
			CREATE_EOP: begin
				cmd.create_eop = 1'b1;
				next_state = EOP_WAIT;
			end
			EOP_WAIT: begin
				cmd.tx_enable = 1'b1;
				if (byte_sent)
					next_state = IDLE;
			end
			default:
				next_state = IDLE;
		endcase
	end

	assign busy = (state != IDLE);

	a_load_tx_excl: assert property (@(posedge clk) disable iff (!n_rst)
		!(cmd.load && cmd.tx_enable));
	a_state_legal: assert property (@(posedge clk) disable iff (!n_rst)
		state inside {IDLE, LOAD_INIT, LOAD_PID, TRANSMIT_INIT, READ_INIT, POP_WAIT,
			CHK_DATA, LOAD, START_TX, READ, LOAD_CRC, TX_CRC, CREATE_EOP, EOP_WAIT});

endmodule

`default_nettype wire

/* hdl/usb_tx_apb_regs.sv */
/*
 * APB slave for the transmitter
 * DATA pushes into the FIFO, CTRL starts a packet, STATUS reports state
 */
`default_nettype none

module usb_tx_apb_regs (
	input logic clk,
	input logic n_rst,
	input usb_tx_pkg::apb_req_t apb_req,
	output usb_tx_pkg::apb_rsp_t apb_rsp,
	input logic busy,
	input logic fifo_empty,
	input logic fifo_full,
	input logic [3:0] fifo_count,
	output logic push,
	output logic [7:0] wdata,
	output logic start
);

	logic access;
	logic wr_data;
	logic wr_start;
	logic rd_status;

	// Zero wait states, so everything happens in the access phase
	assign access = apb_req.psel && apb_req.penable;
	assign wr_data = access && apb_req.pwrite && (apb_req.paddr == usb_tx_pkg::ADDR_DATA);
	assign wr_start = access && apb_req.pwrite && (apb_req.paddr == usb_tx_pkg::ADDR_CTRL)
		&& apb_req.pwdata[0];
	assign rd_status = access && !apb_req.pwrite
		&& (apb_req.paddr == usb_tx_pkg::ADDR_STATUS);

	assign push = wr_data && !fifo_full;
	assign wdata = apb_req.pwdata[7:0];
	assign start = wr_start && !fifo_empty && !busy;

	always_comb begin
		apb_rsp = '0;
		apb_rsp.pready = 1'b1;
		apb_rsp.pslverr = (wr_data && fifo_full) || (wr_start && (fifo_empty || busy));
		if (rd_status) begin
			apb_rsp.prdata[0] = busy;
			apb_rsp.prdata[1] = fifo_empty;
			apb_rsp.prdata[2] = fifo_full;
			apb_rsp.prdata[7:4] = fifo_count;
		end
	end

	// An accepted start must be picked up by the controller
	a_start_idle: assert property (@(posedge clk) disable iff (!n_rst)
		start |-> !busy ##1 busy);

endmodule

`default_nettype wire

/* hdl/usb_tx_fifo.sv */
/*
 * Byte FIFO for transmit data
 * Circular buffer with count, empty and full flags
 */
`default_nettype none

module usb_tx_fifo (
	input logic clk,
	input logic n_rst,
	input logic push,
	input logic [7:0] wdata,
	input logic pop,
	output logic [7:0] rdata,
	output logic empty,
	output logic full,
	output logic [3:0] count
);

	localparam int AW = $clog2(usb_tx_pkg::FIFO_DEPTH);

	logic [7:0] mem [usb_tx_pkg::FIFO_DEPTH];
	logic [AW-1:0] wptr;
	logic [AW-1:0] rptr;

	always_ff @(posedge clk) begin
		if (push)
			mem[wptr] <= wdata;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wptr <= wptr + 1'b1;
			if (pop)
				rptr <= rptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head byte is visible without a pop
	assign rdata = mem[rptr];
	assign empty = (count == 4'd0);
	assign full = (count == 4'(usb_tx_pkg::FIFO_DEPTH));

	a_no_overflow: assert property (@(posedge clk) disable iff (!n_rst)
		push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!n_rst)
		pop |-> !empty);

endmodule

`default_nettype wire

/* hdl/usb_tx_pkg.sv */
/*
 * Shared constants and types for the USB transmitter:
 * FIFO and bit timing parameters, CRC16 constants, register map,
 * APB request/response structs, encoder command and line structs
 */
`default_nettype none

package usb_tx_pkg;

	localparam int FIFO_DEPTH = 8;
	localparam int BIT_CLKS = 4;

	localparam logic [7:0] SYNC_BYTE = 8'h80;
	localparam logic [15:0] CRC_INIT = 16'hFFFF;
	// x^16 + x^15 + x^2 + 1, bit reversed
	localparam logic [15:0] CRC_POLY = 16'hA001;

	localparam logic [7:0] ADDR_DATA = 8'h00;
	localparam logic [7:0] ADDR_CTRL = 8'h04;
	localparam logic [7:0] ADDR_STATUS = 8'h08;

	// Encoder byte select
	localparam logic [1:0] SEL_SYNC = 2'd0;
	localparam logic [1:0] SEL_FIFO = 2'd1;
	localparam logic [1:0] SEL_CRC_LO = 2'd2;
	localparam logic [1:0] SEL_CRC_HI = 2'd3;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic load;
		logic tx_enable;
		logic create_eop;
		logic [1:0] sel;
	} tx_cmd_t;

	typedef struct packed {
		logic dp;
		logic dm;
		logic oe;
	} usb_line_t;

endpackage

`default_nettype wire
